// ==== common/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [15:0] half_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  alu_func_t;
  typedef logic [3:0]  lane_mask_t;
  typedef logic [3:0]  ccr_t;  // c n v z from the top bit

  localparam int CCR_C = 3;
  localparam int CCR_N = 2;
  localparam int CCR_V = 1;
  localparam int CCR_Z = 0;

  localparam alu_func_t ALU_AND  = 3'd0;
  localparam alu_func_t ALU_OR   = 3'd1;
  localparam alu_func_t ALU_ADD  = 3'd2;
  localparam alu_func_t ALU_SUB  = 3'd3;
  localparam alu_func_t ALU_XOR  = 3'd4;
  localparam alu_func_t ALU_SHL  = 3'd5;
  localparam alu_func_t ALU_SHR  = 3'd6;
  localparam alu_func_t ALU_PASS = 3'd7;

  localparam lane_mask_t LANE_NONE = 4'b0000;
  localparam lane_mask_t LANE_B0   = 4'b0001;
  localparam lane_mask_t LANE_W0   = 4'b0011;
  localparam lane_mask_t LANE_W1   = 4'b1100;
  localparam lane_mask_t LANE_DW   = 4'b1111;

  // instruction format, opcode bits 15:14
  localparam logic [1:0] FMT_F0 = 2'b00;
  localparam logic [1:0] FMT_F1 = 2'b01;
  localparam logic [1:0] FMT_F2 = 2'b10;
  localparam logic [1:0] FMT_F3 = 2'b11;

  // sub-opcodes live in opcode bits 12:5, register field in 4:0
  localparam logic [7:0] OP_NOP = 8'h00;
  localparam logic [7:0] OP_RTS = 8'h01;
  localparam logic [7:0] OP_INC = 8'h03;
  localparam logic [7:0] OP_DEC = 8'h04;

  localparam logic [4:0] OP_ALU_GRP = 5'b00000;  // sub-op bits 7:3, func in 2:0
  localparam logic [7:0] OP_LDI  = 8'h10;
  localparam logic [7:0] OP_MOV  = 8'h10;
  localparam logic [7:0] OP_CMP  = 8'h11;
  localparam logic [7:0] OP_ST_L = 8'h20;
  localparam logic [7:0] OP_LD_L = 8'h21;
  localparam logic [7:0] OP_ST_W = 8'h30;
  localparam logic [7:0] OP_LD_W = 8'h31;
  localparam logic [7:0] OP_ST_B = 8'h40;
  localparam logic [7:0] OP_LD_B = 8'h41;
  localparam logic [7:0] OP_JMP  = 8'h50;
  localparam logic [7:0] OP_JSR  = 8'h51;

  localparam logic [7:0] OP_BRA = 8'h20;
  localparam logic [7:0] OP_BEQ = 8'h21;
  localparam logic [7:0] OP_BNE = 8'h22;
  localparam logic [7:0] OP_BGT = 8'h24;
  localparam logic [7:0] OP_BGE = 8'h25;
  localparam logic [7:0] OP_BLE = 8'h26;
  localparam logic [7:0] OP_BLT = 8'h27;

  typedef enum logic [4:0] {
    fetch1_w, fetch1, fetch2_w, fetch2,
    memop1_w, memop1, memop2_w, memop2,
    load, load2, load3, load4,
    store, store2, store3,
    call1, call2, call3, call4,
    rtn1_w, rtn1, rtn2_w, rtn2,
    fault
  } ctrl_state_t;

endpackage

// ==== cpu/alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
  input  word_t     a,
  input  word_t     b,
  input  alu_func_t func,
  output word_t     y,
  output ccr_t      flags
);

  logic [32:0] wide;
  logic        carry;
  logic        ovf;

  always_comb begin
    wide  = '0;
    carry = 1'b0;
    ovf   = 1'b0;
    y     = a;
    case (func)
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_XOR: y = a ^ b;
      ALU_SHL: y = a << b[4:0];
      ALU_SHR: y = a >> b[4:0];
      ALU_ADD: begin
        wide  = {1'b0, a} + {1'b0, b};
        y     = wide[31:0];
        carry = wide[32];
        ovf   = (a[31] == b[31]) && (y[31] != a[31]);
      end
      ALU_SUB: begin
        wide  = {1'b0, a} - {1'b0, b};
        y     = wide[31:0];
        carry = wide[32];  // borrow
        ovf   = (a[31] != b[31]) && (y[31] != a[31]);
      end
      default: y = a;
    endcase
  end

  always_comb begin
    flags        = '0;
    flags[CCR_C] = carry;
    flags[CCR_N] = y[31];
    flags[CCR_V] = ovf;
    flags[CCR_Z] = (y == '0);
  end

endmodule

// ==== cpu/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control import cpu_pkg::*; #(
  parameter word_t RESET_PC  = 32'h0000_0000,
  parameter word_t STACK_TOP = 32'h0000_0800
) (
  input  logic       clk,
  input  logic       rst_n,
  input  half_t      rd_data,
  output word_t      addrbus,
  output half_t      data_out,
  output logic       write_out,
  output ccr_t       ccr,
  output logic       fault,
  output reg_addr_t  rd_addr1,
  output reg_addr_t  rd_addr2,
  input  word_t      rd_data1,
  input  word_t      rd_data2,
  output reg_addr_t  wr_addr,
  output word_t      wr_data,
  output lane_mask_t wr_lanes,
  output word_t      alu_a,
  output word_t      alu_b,
  output alu_func_t  alu_func,
  input  ccr_t       alu_flags,
  input  word_t      alu_y
);

  ctrl_state_t state, state_next;
  word_t       pc, pc_next;
  word_t       mar, mar_next;
  word_t       sp, sp_next;
  half_t       opcode, opcode_next;
  half_t       data_out_next;
  half_t       ret_low, ret_low_next;  // low half of the return pc during jsr
  logic        write_out_next;
  logic        mar_access, mar_access_next;
  ccr_t        ccr_next;

  logic [1:0]  fmt;
  logic [7:0]  sub_op;
  word_t       pc_inc;
  word_t       abs_addr;
  word_t       branch_target;

  assign fmt           = opcode[15:14];
  assign sub_op        = opcode[12:5];
  assign pc_inc        = pc + 32'd2;
  assign abs_addr      = {mar[31:16], rd_data};
  assign branch_target = pc_inc + {{15{rd_data[15]}}, rd_data, 1'b0};
  assign addrbus       = mar_access ? mar : pc;
  assign fault         = (state == cpu_pkg::fault);

  function automatic logic cond_met(input logic [7:0] op, input ccr_t f);
    logic z;
    logic lt;
    z  = f[CCR_Z];
    lt = f[CCR_N] ^ f[CCR_V];  // signed less than
    case (op)
      OP_BEQ:  cond_met = z;
      OP_BNE:  cond_met = !z;
      OP_BGT:  cond_met = !(z || lt);
      OP_BGE:  cond_met = !lt;
      OP_BLE:  cond_met = z || lt;
      OP_BLT:  cond_met = lt;
      default: cond_met = 1'b1;
    endcase
  endfunction

  // first bus word of a store
  function automatic half_t store_half(input logic [7:0] op, input word_t value);
    case (op)
      OP_ST_L: store_half = value[31:16];
      OP_ST_B: store_half = {8'h00, value[7:0]};
      default: store_half = value[15:0];
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= fetch1_w;
      pc         <= RESET_PC;
      sp         <= STACK_TOP;
      opcode     <= '0;
      ccr        <= '0;
      write_out  <= 1'b0;
      mar_access <= 1'b0;
    end else begin
      state      <= state_next;
      pc         <= pc_next;
      sp         <= sp_next;
      opcode     <= opcode_next;
      ccr        <= ccr_next;
      write_out  <= write_out_next;
      mar_access <= mar_access_next;
    end
  end

  always_ff @(posedge clk) begin
    mar      <= mar_next;
    data_out <= data_out_next;
    ret_low  <= ret_low_next;
  end

  always_comb begin
    state_next      = state;
    pc_next         = pc;
    mar_next        = mar;
    sp_next         = sp;
    opcode_next     = opcode;
    data_out_next   = data_out;
    ret_low_next    = ret_low;
    write_out_next  = write_out;
    mar_access_next = mar_access;
    ccr_next        = ccr;
    rd_addr1        = '0;
    rd_addr2        = '0;
    wr_addr         = '0;
    wr_data         = '0;
    wr_lanes        = LANE_NONE;
    alu_a           = '0;
    alu_b           = '0;
    alu_func        = ALU_PASS;

    case (state)
      fetch1_w: state_next = fetch1;
      fetch1: begin
        pc_next     = pc_inc;
        opcode_next = rd_data;
        if (rd_data[15:14] == FMT_F3) begin
          state_next = memop1_w;
        end else if (rd_data[15:14] != FMT_F0) begin
          state_next = fetch2_w;
        end else begin
          case (rd_data[12:5])
            OP_NOP: state_next = fetch1_w;
            OP_RTS: begin
              state_next      = rtn1_w;
              mar_next        = sp;
              mar_access_next = 1'b1;
            end
            OP_INC, OP_DEC: begin
              state_next = fetch1_w;
              rd_addr1   = rd_data[4:0];
              alu_a      = rd_data1;
              alu_b      = 32'd1;
              alu_func   = (rd_data[12:5] == OP_INC) ? ALU_ADD : ALU_SUB;
              wr_addr    = rd_data[4:0];
              wr_data    = alu_y;
              wr_lanes   = LANE_DW;
            end
            default: state_next = cpu_pkg::fault;
          endcase
        end
      end
      fetch2_w: state_next = fetch2;
      fetch2: begin
        pc_next    = pc_inc;
        state_next = fetch1_w;
        if (fmt == FMT_F1 && sub_op[7:3] == OP_ALU_GRP) begin
          rd_addr1 = rd_data[12:8];
          rd_addr2 = rd_data[4:0];
          alu_a    = rd_data1;
          alu_b    = rd_data2;
          alu_func = sub_op[2:0];
          wr_addr  = opcode[4:0];
          wr_data  = alu_y;
          wr_lanes = LANE_DW;
        end else if (fmt == FMT_F1) begin
          case (sub_op)
            OP_MOV: begin
              rd_addr1 = rd_data[12:8];
              alu_a    = rd_data1;
              wr_addr  = opcode[4:0];
              wr_data  = alu_y;
              wr_lanes = LANE_DW;
            end
            OP_CMP: begin
              rd_addr1 = opcode[4:0];
              rd_addr2 = rd_data[12:8];
              alu_a    = rd_data1;
              alu_b    = rd_data2;
              alu_func = ALU_SUB;
              ccr_next = alu_flags;
            end
            OP_ST_L, OP_ST_W, OP_ST_B: begin
              rd_addr1        = rd_data[12:8];  // address register
              rd_addr2        = opcode[4:0];
              mar_next        = rd_data1;
              data_out_next   = store_half(sub_op, rd_data2);
              mar_access_next = 1'b1;
              write_out_next  = 1'b1;
              state_next      = store;
            end
            OP_LD_L, OP_LD_W, OP_LD_B: begin
              rd_addr1        = rd_data[12:8];
              mar_next        = rd_data1;
              mar_access_next = 1'b1;
              state_next      = load;
            end
            default: state_next = cpu_pkg::fault;
          endcase
        end else begin
          case (sub_op)
            OP_BRA, OP_BEQ, OP_BNE, OP_BGT, OP_BGE, OP_BLE, OP_BLT: begin
              if (cond_met(sub_op, ccr)) begin
                pc_next = branch_target;
              end
            end
            default: state_next = cpu_pkg::fault;
          endcase
        end
      end
      memop1_w: state_next = memop1;
      memop1: begin
        pc_next         = pc_inc;
        mar_next[31:16] = rd_data;  // high half of the operand
        state_next      = memop2_w;
      end
      memop2_w: state_next = memop2;
      memop2: begin
        pc_next  = pc_inc;
        mar_next = abs_addr;
        case (sub_op)
          OP_ST_L, OP_ST_W, OP_ST_B: begin
            rd_addr2        = opcode[4:0];
            data_out_next   = store_half(sub_op, rd_data2);
            mar_access_next = 1'b1;
            write_out_next  = 1'b1;
            state_next      = store;
          end
          OP_LD_L, OP_LD_W, OP_LD_B: begin
            mar_access_next = 1'b1;
            state_next      = load;
          end
          OP_JMP: begin
            pc_next    = abs_addr;
            state_next = fetch1_w;
          end
          OP_JSR: begin
            pc_next         = abs_addr;
            mar_next        = sp - 32'd2;
            data_out_next   = pc_inc[31:16];  // return pc, high half pushed first
            ret_low_next    = pc_inc[15:0];
            mar_access_next = 1'b1;
            write_out_next  = 1'b1;
            state_next      = call1;
          end
          OP_LDI: begin
            wr_addr    = opcode[4:0];
            wr_data    = abs_addr;
            wr_lanes   = LANE_DW;
            state_next = fetch1_w;
          end
          default: state_next = cpu_pkg::fault;
        endcase
      end
      store: begin
        write_out_next = 1'b0;
        state_next     = (sub_op == OP_ST_L) ? store2 : store3;
      end
      store2: begin
        rd_addr2       = opcode[4:0];
        mar_next       = mar + 32'd2;
        data_out_next  = rd_data2[15:0];
        write_out_next = 1'b1;
        // low half goes out as a plain word store
        opcode_next    = {opcode[15:13], OP_ST_W, opcode[4:0]};
        state_next     = store;
      end
      store3: begin
        mar_access_next = 1'b0;
        state_next      = fetch1_w;
      end
      load: state_next = load2;
      load2: begin
        wr_addr = opcode[4:0];
        case (sub_op)
          OP_LD_L: begin
            wr_data    = {rd_data, 16'h0000};
            wr_lanes   = LANE_W1;
            mar_next   = mar + 32'd2;
            state_next = load3;
          end
          OP_LD_B: begin
            wr_data         = {24'h000000, rd_data[7:0]};
            wr_lanes        = LANE_DW;
            mar_access_next = 1'b0;
            state_next      = fetch1_w;
          end
          default: begin
            wr_data         = {16'h0000, rd_data};
            wr_lanes        = LANE_DW;
            mar_access_next = 1'b0;
            state_next      = fetch1_w;
          end
        endcase
      end
      load3: state_next = load4;
      load4: begin
        wr_addr         = opcode[4:0];
        wr_data         = {16'h0000, rd_data};
        wr_lanes        = LANE_W0;
        mar_access_next = 1'b0;
        state_next      = fetch1_w;
      end
      call1: begin
        write_out_next = 1'b0;
        state_next     = call2;
      end
      call2: begin
        mar_next       = mar - 32'd2;
        data_out_next  = ret_low;
        write_out_next = 1'b1;
        state_next     = call3;
      end
      call3: begin
        write_out_next = 1'b0;
        state_next     = call4;
      end
      call4: begin
        sp_next         = sp - 32'd4;
        mar_access_next = 1'b0;
        state_next      = fetch1_w;
      end
      rtn1_w: state_next = rtn1;
      rtn1: begin
        pc_next[15:0] = rd_data;  // low half sits at sp
        mar_next      = mar + 32'd2;
        state_next    = rtn2_w;
      end
      rtn2_w: state_next = rtn2;
      rtn2: begin
        pc_next[31:16]  = rd_data;
        sp_next         = sp + 32'd4;
        mar_access_next = 1'b0;
        state_next      = fetch1_w;
      end
      default: state_next = cpu_pkg::fault;  // held until reset
    endcase
  end

endmodule

// ==== cpu/register_file.sv ====
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  reg_addr_t  rd_addr1,
  input  reg_addr_t  rd_addr2,
  input  reg_addr_t  wr_addr,
  input  word_t      wr_data,
  input  lane_mask_t wr_lanes,
  output word_t      rd_data1,
  output word_t      rd_data2
);

  word_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int lane = 0; lane < 4; lane++) begin
        if (wr_lanes[lane]) begin
          regs[wr_addr][lane*8 +: 8] <= wr_data[lane*8 +: 8];
        end
      end
    end
  end

  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

endmodule

// ==== rtl/cpu_system.sv ====
`timescale 1ns/1ps

module cpu_system import cpu_pkg::*; #(
  parameter word_t RESET_PC  = 32'h0000_0000,
  parameter word_t STACK_TOP = 32'h0000_0800,
  parameter int    MEM_WORDS = 1024
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  load_en,
  input  word_t load_addr,
  input  half_t load_data,
  output word_t addrbus,
  output half_t data_out,
  output logic  write_out,
  output ccr_t  ccr,
  output logic  fault
);

  half_t      mem_rd_data;
  reg_addr_t  rd_addr1;
  reg_addr_t  rd_addr2;
  reg_addr_t  wr_addr;
  word_t      rd_data1;
  word_t      rd_data2;
  word_t      wr_data;
  lane_mask_t wr_lanes;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_y;
  alu_func_t  alu_func;
  ccr_t       alu_flags;

  sync_memory #(
    .MEM_WORDS(MEM_WORDS)
  ) u_memory (
    .clk       (clk),
    .addr      (addrbus),
    .wr_en     (write_out),
    .wr_data   (data_out),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd_data   (mem_rd_data)
  );

  cpu_control #(
    .RESET_PC  (RESET_PC),
    .STACK_TOP (STACK_TOP)
  ) u_control (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_data   (mem_rd_data),
    .addrbus   (addrbus),
    .data_out  (data_out),
    .write_out (write_out),
    .ccr       (ccr),
    .fault     (fault),
    .rd_addr1  (rd_addr1),
    .rd_addr2  (rd_addr2),
    .rd_data1  (rd_data1),
    .rd_data2  (rd_data2),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_lanes  (wr_lanes),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_func  (alu_func),
    .alu_flags (alu_flags),
    .alu_y     (alu_y)
  );

  alu u_alu (
    .a     (alu_a),
    .b     (alu_b),
    .func  (alu_func),
    .y     (alu_y),
    .flags (alu_flags)
  );

  register_file u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_addr1 (rd_addr1),
    .rd_addr2 (rd_addr2),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_lanes (wr_lanes),
    .rd_data1 (rd_data1),
    .rd_data2 (rd_data2)
  );

endmodule

// ==== rtl/sync_memory.sv ====
`timescale 1ns/1ps

module sync_memory import cpu_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  logic  clk,
  input  word_t addr,
  input  logic  wr_en,
  input  half_t wr_data,
  input  logic  load_en,
  input  word_t load_addr,
  input  half_t load_data,
  output half_t rd_data
);

  localparam int AW = $clog2(MEM_WORDS);

  half_t         mem [MEM_WORDS];
  logic [AW-1:0] cpu_idx;
  logic [AW-1:0] load_idx;

  // both ports take byte addresses, bit 0 ignored, upper bits alias
  assign cpu_idx  = addr[AW:1];
  assign load_idx = load_addr[AW:1];

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_idx] <= load_data;
    end else if (wr_en) begin
      mem[cpu_idx] <= wr_data;
    end
    rd_data <= mem[cpu_idx];  // old data on a same-cycle write
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cpu_system testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f verilog.f --top-module tb_cpu_system -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_cpu_system > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
  exit 1
fi
if ! grep -qF '*** PASSED ***' "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0

// ==== test/tb_isa_model.svh ====
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

function automatic half_t asm_word(input logic [1:0] fmt, input logic [7:0] sub,
                                   input reg_addr_t r);
  asm_word = {fmt, 1'b0, sub, r};
endfunction

task automatic emit(input half_t w);
  image[prog_pos] = w;
  prog_pos++;
endtask

task automatic new_program();
  for (int i = 0; i < MEM_WORDS; i++) begin
    image[i] = 16'h5A00 ^ i[15:0];  // fill follows the word index
  end
  prog_pos = 0;
endtask

task automatic asm_f0(input logic [7:0] sub, input reg_addr_t r);
  emit(asm_word(FMT_F0, sub, r));
endtask

task automatic asm_f1(input logic [7:0] sub, input reg_addr_t rd, input reg_addr_t ra,
                      input reg_addr_t rb);
  emit(asm_word(FMT_F1, sub, rd));
  emit({3'b000, ra, 3'b000, rb});
endtask

task automatic asm_f3(input logic [7:0] sub, input reg_addr_t r, input word_t value);
  emit(asm_word(FMT_F3, sub, r));
  emit(value[31:16]);
  emit(value[15:0]);
endtask

task automatic asm_branch(input logic [7:0] sub, input half_t skip_words);
  emit(asm_word(FMT_F2, sub, 5'd0));
  emit(skip_words);
endtask

function automatic half_t mread(input word_t a);
  mread = model_mem[a[MEM_AW:1]];
endfunction

function automatic void mwrite(input word_t a, input half_t d);
  model_mem[a[MEM_AW:1]] = d;
  exp_addr.push_back(a);
  exp_data.push_back(d);
endfunction

function automatic void model_store(input logic [7:0] sub, input word_t a, input word_t v);
  case (sub)
    OP_ST_L: begin
      mwrite(a, v[31:16]);
      mwrite(a + 32'd2, v[15:0]);
    end
    OP_ST_B: mwrite(a, {8'h00, v[7:0]});
    default: mwrite(a, v[15:0]);
  endcase
endfunction

function automatic word_t model_load(input logic [7:0] sub, input word_t a);
  half_t lo;
  lo = mread(a);
  case (sub)
    OP_LD_L: model_load = {lo, mread(a + 32'd2)};
    OP_LD_B: model_load = {24'h000000, lo[7:0]};
    default: model_load = {16'h0000, lo};
  endcase
endfunction

function automatic word_t alu_ref(input logic [2:0] func, input word_t a, input word_t b);
  case (func)
    ALU_AND: alu_ref = a & b;
    ALU_OR:  alu_ref = a | b;
    ALU_ADD: alu_ref = a + b;
    ALU_SUB: alu_ref = a - b;
    ALU_XOR: alu_ref = a ^ b;
    ALU_SHL: alu_ref = a << b[4:0];
    ALU_SHR: alu_ref = a >> b[4:0];
    default: alu_ref = a;
  endcase
endfunction

function automatic ccr_t cmp_flags(input word_t a, input word_t b);
  logic signed [32:0] sd;
  word_t d;
  sd = $signed({a[31], a}) - $signed({b[31], b});
  d  = a - b;
  cmp_flags = {a < b, d[31], sd[32] != sd[31], d == 32'd0};
endfunction

function automatic logic branch_taken(input logic [7:0] sub, input ccr_t f);
  logic lt;
  lt = f[CCR_N] != f[CCR_V];
  case (sub)
    OP_BEQ:  branch_taken = f[CCR_Z];
    OP_BNE:  branch_taken = !f[CCR_Z];
    OP_BGT:  branch_taken = !f[CCR_Z] && !lt;
    OP_BGE:  branch_taken = !lt;
    OP_BLE:  branch_taken = f[CCR_Z] || lt;
    OP_BLT:  branch_taken = lt;
    default: branch_taken = 1'b1;
  endcase
endfunction

// steps the ISA over image, fills the expected store list, returns instruction count
function automatic int isa_run();
  int        count;
  logic      done;
  word_t     pc;
  word_t     sp;
  word_t     a;
  ccr_t      flags;
  half_t     w1;
  half_t     w2;
  logic [7:0] sub;
  reg_addr_t r;
  count = 0;
  done  = 1'b0;
  pc    = RESET_PC;
  sp    = STACK_TOP;
  flags = '0;
  exp_addr.delete();
  exp_data.delete();
  for (int i = 0; i < 32; i++) begin
    model_regs[i] = '0;
  end
  for (int i = 0; i < MEM_WORDS; i++) begin
    model_mem[i] = image[i];
  end
  while (!done && count < 4000) begin
    w1 = mread(pc);
    pc = pc + 32'd2;
    count++;
    sub = w1[12:5];
    r   = w1[4:0];
    case (w1[15:14])
      FMT_F0: begin
        case (sub)
          OP_NOP: ;
          OP_RTS: begin
            pc = {mread(sp + 32'd2), mread(sp)};
            sp = sp + 32'd4;
          end
          OP_INC:  model_regs[r] = model_regs[r] + 32'd1;
          OP_DEC:  model_regs[r] = model_regs[r] - 32'd1;
          default: done = 1'b1;
        endcase
      end
      FMT_F1: begin
        w2 = mread(pc);
        pc = pc + 32'd2;
        if (sub[7:3] == 5'b00000) begin
          model_regs[r] = alu_ref(sub[2:0], model_regs[w2[12:8]], model_regs[w2[4:0]]);
        end else begin
          case (sub)
            OP_MOV: model_regs[r] = model_regs[w2[12:8]];
            OP_CMP: flags = cmp_flags(model_regs[r], model_regs[w2[12:8]]);
            OP_ST_L, OP_ST_W, OP_ST_B: model_store(sub, model_regs[w2[12:8]], model_regs[r]);
            OP_LD_L, OP_LD_W, OP_LD_B: model_regs[r] = model_load(sub, model_regs[w2[12:8]]);
            default: done = 1'b1;
          endcase
        end
      end
      FMT_F2: begin
        w2 = mread(pc);
        pc = pc + 32'd2;
        case (sub)
          OP_BRA, OP_BEQ, OP_BNE, OP_BGT, OP_BGE, OP_BLE, OP_BLT: begin
            if (branch_taken(sub, flags)) begin
              pc = pc + word_t'(int'($signed(w2)) * 2);
            end
          end
          default: done = 1'b1;
        endcase
      end
      default: begin
        a  = {mread(pc), mread(pc + 32'd2)};
        pc = pc + 32'd4;
        case (sub)
          OP_ST_L, OP_ST_W, OP_ST_B: model_store(sub, a, model_regs[r]);
          OP_LD_L, OP_LD_W, OP_LD_B: model_regs[r] = model_load(sub, a);
          OP_JMP: pc = a;
          OP_JSR: begin
            mwrite(sp - 32'd2, pc[31:16]);
            mwrite(sp - 32'd4, pc[15:0]);
            sp = sp - 32'd4;
            pc = a;
          end
          OP_LDI:  model_regs[r] = a;
          default: done = 1'b1;
        endcase
      end
    endcase
  end
  exp_fault = done;
  exp_ccr   = flags;
  isa_run   = count;
endfunction

task automatic build_alu_test();
  word_t a;
  word_t b;
  a = $random(seed);
  b = $random(seed);
  asm_f3(OP_LDI, 5'd1, a);
  asm_f3(OP_LDI, 5'd2, b);
  for (int f = 0; f < 8; f++) begin
    asm_f1({5'b00000, f[2:0]}, reg_addr_t'(3 + f), 5'd1, 5'd2);
    asm_f3(OP_ST_L, reg_addr_t'(3 + f), 32'h400 + f * 8);
  end
  asm_f0(OP_INC, 5'd1);
  asm_f0(OP_DEC, 5'd2);
  asm_f1(OP_MOV, 5'd12, 5'd1, 5'd0);
  asm_f3(OP_ST_L, 5'd1, 32'h440);
  asm_f3(OP_ST_L, 5'd2, 32'h448);
  asm_f3(OP_ST_L, 5'd12, 32'h450);
  asm_f0(8'hFF, 5'd0);
endtask

task automatic build_branch_test();
  logic [7:0] br_ops [7];
  word_t a;
  word_t b;
  br_ops = '{OP_BRA, OP_BEQ, OP_BNE, OP_BGT, OP_BGE, OP_BLE, OP_BLT};
  asm_f3(OP_LDI, 5'd20, 32'h0000_1111);  // not-taken marker
  asm_f3(OP_LDI, 5'd21, 32'h0000_2222);
  for (int p = 0; p < 3; p++) begin
    a = $random(seed);
    b = $random(seed);
    if (p == 1) b = a;
    if (p == 2) b = a ^ 32'h8000_0000;  // opposite signs
    asm_f3(OP_LDI, 5'd1, a);
    asm_f3(OP_LDI, 5'd2, b);
    asm_f1(OP_CMP, 5'd1, 5'd2, 5'd0);
    for (int i = 0; i < 7; i++) begin
      asm_branch(br_ops[i], 16'd3);
      asm_f3(OP_ST_W, 5'd20, 32'h400 + p * 64 + i * 4);
      asm_f3(OP_ST_W, 5'd21, 32'h402 + p * 64 + i * 4);
    end
  end
  asm_f0(8'hFF, 5'd0);
endtask

task automatic build_mem_test();
  asm_f3(OP_LDI, 5'd1, $random(seed));
  asm_f3(OP_ST_L, 5'd1, 32'h500);
  asm_f3(OP_ST_W, 5'd1, 32'h508);
  asm_f3(OP_ST_B, 5'd1, 32'h50A);
  asm_f3(OP_LD_L, 5'd2, 32'h500);
  asm_f3(OP_LD_W, 5'd3, 32'h500);
  asm_f3(OP_LD_B, 5'd4, 32'h502);
  asm_f3(OP_LDI, 5'd5, 32'h510);
  asm_f3(OP_LDI, 5'd8, 32'h520);
  asm_f3(OP_LDI, 5'd9, 32'h524);
  asm_f1(OP_ST_L, 5'd2, 5'd5, 5'd0);
  asm_f1(OP_ST_W, 5'd1, 5'd8, 5'd0);
  asm_f1(OP_ST_B, 5'd1, 5'd9, 5'd0);
  asm_f1(OP_LD_L, 5'd6, 5'd5, 5'd0);
  asm_f1(OP_LD_W, 5'd7, 5'd8, 5'd0);
  asm_f1(OP_LD_B, 5'd10, 5'd9, 5'd0);
  asm_f3(OP_ST_L, 5'd3, 32'h540);
  asm_f3(OP_ST_L, 5'd4, 32'h544);
  asm_f3(OP_ST_L, 5'd6, 32'h548);
  asm_f3(OP_ST_L, 5'd7, 32'h54C);
  asm_f3(OP_ST_L, 5'd10, 32'h550);
  asm_f0(8'hFF, 5'd0);
endtask

task automatic build_call_test();
  for (int i = 1; i < 5; i++) begin
    asm_f3(OP_LDI, reg_addr_t'(i), $random(seed));
  end
  asm_f3(OP_JSR, 5'd0, 32'h200);
  asm_f3(OP_ST_L, 5'd1, 32'h580);
  asm_f0(8'hFF, 5'd0);
  prog_pos = 'h100;  // outer routine at 0x200
  asm_f3(OP_ST_L, 5'd2, 32'h588);
  asm_f3(OP_JSR, 5'd0, 32'h300);
  asm_f3(OP_ST_L, 5'd3, 32'h590);
  asm_f0(OP_RTS, 5'd0);
  prog_pos = 'h180;
  asm_f3(OP_ST_L, 5'd4, 32'h598);
  asm_f0(OP_RTS, 5'd0);
endtask

task automatic build_jump_test();
  asm_f3(OP_LDI, 5'd1, $random(seed));
  asm_branch(OP_BRA, 16'd3);
  asm_f3(OP_ST_L, 5'd1, 32'h600);  // skipped
  asm_f3(OP_ST_L, 5'd1, 32'h604);
  asm_f3(OP_JMP, 5'd0, prog_pos * 2 + 12);
  asm_f3(OP_ST_L, 5'd1, 32'h608);  // skipped
  asm_f3(OP_ST_W, 5'd1, 32'h60C);
  emit(asm_word(FMT_F2, 8'h23, 5'd0));
  emit(16'h0000);
  asm_f3(OP_ST_L, 5'd1, 32'h610);  // never reached
endtask

task automatic build_program(input int t);
  new_program();
  case (t)
    0: build_alu_test();
    1: build_branch_test();
    2: build_mem_test();
    3: build_call_test();
    default: build_jump_test();
  endcase
endtask

function automatic string test_name(input int t);
  case (t)
    0: test_name = "alu ops";
    1: test_name = "compare and branch";
    2: test_name = "loads and stores";
    3: test_name = "jsr and rts";
    default: test_name = "jumps and fault";
  endcase
endfunction

`endif

// ==== test/tb_cpu_system.sv ====
`timescale 1ns/1ps

module tb_cpu_system import cpu_pkg::*; ();

  localparam word_t RESET_PC   = 32'h0000_0000;
  localparam word_t STACK_TOP  = 32'h0000_0800;
  localparam int    MEM_WORDS  = 1024;
  localparam int    MEM_AW     = 10;
  localparam int    NUM_TESTS  = 5;
  localparam int    CLK_PERIOD = 8;

  logic  clk;
  logic  rst_n;
  logic  load_en;
  word_t load_addr;
  half_t load_data;
  word_t addrbus;
  half_t data_out;
  logic  write_out;
  ccr_t  ccr;
  logic  fault;

  half_t  image [MEM_WORDS];
  half_t  images [NUM_TESTS][MEM_WORDS];
  half_t  model_mem [MEM_WORDS];
  word_t  model_regs [32];
  int     prog_pos;
  integer seed;

  word_t exp_addr [$];
  half_t exp_data [$];
  ccr_t  exp_ccr;
  logic  exp_fault;
  word_t obs_addr [$];
  half_t obs_data [$];
  logic  obs_flt [$];
  int    obs_count;
  int    test_errors;
  int    total_errors;
  int    tests_failed;
  int    limit_ns;
  logic  limit_ready;

  `include "tb_isa_model.svh"

  cpu_system #(
    .RESET_PC  (RESET_PC),
    .STACK_TOP (STACK_TOP),
    .MEM_WORDS (MEM_WORDS)
  ) u_cpu_system (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .addrbus   (addrbus),
    .data_out  (data_out),
    .write_out (write_out),
    .ccr       (ccr),
    .fault     (fault)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic note_error();
    test_errors++;
    total_errors++;
  endtask

  // the write lands on this edge
  always @(posedge clk) begin
    if (rst_n && write_out) begin
      obs_addr.push_back(addrbus);
      obs_data.push_back(data_out);
      obs_flt.push_back(fault);
    end
  end

  task automatic check_store(input word_t a, input half_t d, input logic f);
    assert (!f) else begin
      $display("write_out pulse at %0t while fault is high", $time);
      note_error();
    end
    assert (obs_count < exp_addr.size()) else begin
      $display("store %0d at %0t was not expected by the model", obs_count, $time);
      note_error();
    end
    if (obs_count < exp_addr.size()) begin
      assert (a == exp_addr[obs_count]) else begin
        $display("FAIL %0t addrbus expected %h got %h", $time, exp_addr[obs_count], a);
        note_error();
      end
      assert (d == exp_data[obs_count]) else begin
        $display("FAIL %0t data_out expected %h got %h", $time, exp_data[obs_count], d);
        note_error();
      end
    end
    obs_count++;
  endtask

  always @(negedge clk) begin
    while (obs_addr.size() > 0) begin
      check_store(obs_addr.pop_front(), obs_data.pop_front(), obs_flt.pop_front());
    end
  end

  task automatic load_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      @(negedge clk);
      load_en   = 1'b1;
      load_addr = i * 2;
      load_data = image[i];
    end
    @(negedge clk);
    load_en = 1'b0;
  endtask

  task automatic run_test(input int t);
    int   n;
    int   waited;
    logic fault_seen;
    for (int i = 0; i < MEM_WORDS; i++) begin
      image[i] = images[t][i];
    end
    n = isa_run();
    obs_count   = 0;
    test_errors = 0;
    @(negedge clk);
    rst_n = 1'b0;
    load_memory();
    assert (write_out === 1'b0 && fault === 1'b0 && ccr === '0) else begin
      $display("outputs not cleared during reset at %0t", $time);
      note_error();
    end
    @(negedge clk);
    rst_n = 1'b1;
    waited = 0;
    while (fault !== 1'b1 && waited < n * 40) begin
      @(negedge clk);
      waited++;
    end
    fault_seen = (fault === 1'b1);
    assert (fault_seen == exp_fault) else begin
      $display("FAIL %0t fault expected %b got %b", $time, exp_fault, fault);
      note_error();
    end
    repeat (30) begin  // fault must hold with the bus quiet
      @(negedge clk);
      if (fault_seen) begin
        assert (fault === 1'b1) else begin
          $display("fault dropped at %0t before reset", $time);
          note_error();
        end
      end
    end
    assert (obs_count == exp_addr.size()) else begin
      $display("FAIL %0t store_count expected %0d got %0d", $time, exp_addr.size(), obs_count);
      note_error();
    end
    assert (ccr == exp_ccr) else begin
      $display("FAIL %0t ccr expected %h got %h", $time, exp_ccr, ccr);
      note_error();
    end
    if (test_errors != 0) tests_failed++;
    $display("test %0d %s: %0d instructions, %0d stores, %0d errors", t + 1,
             test_name(t), n, obs_count, test_errors);
  endtask

  initial begin
    int total_instr;
    rst_n        = 1'b0;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    seed         = 14410;
    limit_ready  = 1'b0;
    total_errors = 0;
    tests_failed = 0;
    total_instr  = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      build_program(t);
      for (int i = 0; i < MEM_WORDS; i++) begin
        images[t][i] = image[i];
      end
      total_instr += isa_run();
    end
    limit_ns    = (total_instr * 40 + NUM_TESTS * (MEM_WORDS + 64)) * CLK_PERIOD;
    limit_ready = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    wait (limit_ready);
    #(limit_ns);
    $display("timeout: run still going after %0d ns", limit_ns);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+test
common/cpu_pkg.sv
cpu/alu.sv
cpu/register_file.sv
cpu/cpu_control.sv
rtl/sync_memory.sv
rtl/cpu_system.sv
test/tb_cpu_system.sv
